// ==== src/game_pkg.sv ====
`default_nettype none

package game_pkg;

	localparam int FIELD_W = 8;
	localparam int POS_W = 3;
	localparam int LIFE_W = 4;
	localparam int LIFE_INIT = 15;
	localparam int AMMO_W = 4;
	localparam int AMMO_INIT = 9;

	localparam int A_ROW_INIT = 7; // bottom row, row 0 is on top
	localparam int B_ROW_INIT = 0;
	localparam int COL_INIT = 4;
	localparam int COLUMN_BASE = 8; // matrix columns sit at 8..15

	localparam int SLOT_COUNT = 6;

	localparam int MOVE_DIV_DEF = 15_000_000;
	localparam int SHOT_DIV_DEF = 3_000_000;
	localparam int SCAN_DIV_DEF = 20_000;

	localparam logic [FIELD_W-1:0] OFF_ROW = '1; // colours are active low

	typedef logic [POS_W-1:0] pos_t;

	// active-low segments a..g, dash for anything past 9
	function automatic logic [6:0] seg_digit(input logic [AMMO_W-1:0] value);
		logic [6:0] pattern;
		case (value)
			4'd0: pattern = 7'b0000001;
			4'd1: pattern = 7'b1001111;
			4'd2: pattern = 7'b0010010;
			4'd3: pattern = 7'b0000110;
			4'd4: pattern = 7'b1001100;
			4'd5: pattern = 7'b0100100;
			4'd6: pattern = 7'b0100000;
			4'd7: pattern = 7'b0001111;
			4'd8: pattern = 7'b0000000;
			4'd9: pattern = 7'b0000100;
			default: pattern = 7'b1111110;
		endcase
		return pattern;
	endfunction

endpackage

`default_nettype wire

// ==== src/tick_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tick_gen
	import game_pkg::*;
#(
	parameter int MOVE_DIV = MOVE_DIV_DEF,
	parameter int SHOT_DIV = SHOT_DIV_DEF,
	parameter int SCAN_DIV = SCAN_DIV_DEF
)
(
	input logic CLK,
	input logic Clear,
	output logic move_tick,
	output logic shot_tick,
	output logic scan_tick
);

	localparam int DIV [3] = '{MOVE_DIV, SHOT_DIV, SCAN_DIV};

	logic [2:0] tick;

	for (genvar i = 0; i < 3; i++)
	begin : g_div
		localparam int CW = $clog2(DIV[i]) + 1;

		logic [CW-1:0] cnt;

		assign tick[i] = (cnt == CW'(DIV[i] - 1)); // terminal count

		always_ff @(posedge CLK or posedge Clear)
		begin
			if (Clear)
				cnt <= '0;
			else if (tick[i])
				cnt <= '0;
			else
				cnt <= cnt + 1'b1;
		end

		a_one_cycle: assert property (@(posedge CLK) disable iff (Clear)
			tick[i] |=> !tick[i]);
	end

	assign move_tick = tick[0];
	assign shot_tick = tick[1];
	assign scan_tick = tick[2];

endmodule

`default_nettype wire

// ==== src/player_pos.sv ====
`timescale 1ns/1ps
`default_nettype none

module player_pos
	import game_pkg::*;
#(
	parameter int ROW_INIT = A_ROW_INIT
)
(
	input logic CLK,
	input logic Clear,
	input logic move_tick,
	input logic up,
	input logic down,
	input logic left,
	input logic right,
	output pos_t row,
	output pos_t col
);

	localparam pos_t EDGE = pos_t'(FIELD_W - 1);

	always_ff @(posedge CLK or posedge Clear)
	begin
		if (Clear)
		begin
			row <= pos_t'(ROW_INIT);
			col <= pos_t'(COL_INIT);
		end
		else if (move_tick)
		begin
			// up wins over down, stop at the border
			if (up)
			begin
				if (row != '0)
					row <= pos_t'(row - 1);
			end
			else if (down)
			begin
				if (row != EDGE)
					row <= pos_t'(row + 1);
			end

			if (left)
			begin
				if (col != '0)
					col <= pos_t'(col - 1);
			end
			else if (right)
			begin
				if (col != EDGE)
					col <= pos_t'(col + 1);
			end
		end
	end

	a_row_on_tick: assert property (@(posedge CLK) disable iff (Clear)
		!move_tick |=> $stable(row));

endmodule

`default_nettype wire

// ==== src/shot_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module shot_unit
	import game_pkg::*;
(
	input logic CLK,
	input logic Clear,
	input logic shot_tick,
	input logic attack,
	input logic game_over,
	input pos_t row,
	input pos_t col,
	output logic up_valid,
	output logic down_valid,
	output pos_t up_row,
	output pos_t down_row,
	output pos_t shot_col,
	output logic [AMMO_W-1:0] ammo
);

	localparam pos_t EDGE = pos_t'(FIELD_W - 1);

	logic in_flight;
	logic launch;

	assign in_flight = up_valid || down_valid;
	// one pair at a time, and only while the game runs
	assign launch = shot_tick && !in_flight && attack && (ammo != '0) && !game_over;

	always_ff @(posedge CLK or posedge Clear)
	begin
		if (Clear)
		begin
			ammo <= AMMO_W'(AMMO_INIT);
			up_valid <= 1'b0;
			down_valid <= 1'b0;
		end
		else if (launch)
		begin
			ammo <= ammo - 1'b1;
			up_valid <= (row != '0); // shooter on the top row has no up bullet
			down_valid <= (row != EDGE);
		end
		else if (shot_tick)
		begin
			if (up_valid && up_row == '0)
				up_valid <= 1'b0;
			if (down_valid && down_row == EDGE)
				down_valid <= 1'b0;
		end
	end

	// bullet positions and launch column
	always_ff @(posedge CLK)
	begin
		if (launch)
		begin
			up_row <= pos_t'(row - 1);
			down_row <= pos_t'(row + 1);
			shot_col <= col;
		end
		else if (shot_tick)
		begin
			if (up_valid)
				up_row <= pos_t'(up_row - 1);
			if (down_valid)
				down_row <= pos_t'(down_row + 1);
		end
	end

	a_ammo_max: assert property (@(posedge CLK) disable iff (Clear)
		ammo <= AMMO_W'(AMMO_INIT));

	a_ammo_no_rise: assert property (@(posedge CLK) disable iff (Clear)
		1'b1 |=> ammo <= $past(ammo));

endmodule

`default_nettype wire

// ==== src/hit_judge.sv ====
`timescale 1ns/1ps
`default_nettype none

module hit_judge
	import game_pkg::*;
(
	input logic CLK,
	input logic Clear,
	input logic shot_tick,
	input logic a_defense,
	input logic b_defense,
	input pos_t a_row,
	input pos_t a_col,
	input pos_t b_row,
	input pos_t b_col,
	input logic a_up_valid,
	input logic a_down_valid,
	input pos_t a_up_row,
	input pos_t a_down_row,
	input pos_t a_shot_col,
	input logic b_up_valid,
	input logic b_down_valid,
	input pos_t b_up_row,
	input pos_t b_down_row,
	input pos_t b_shot_col,
	output logic [LIFE_W-1:0] a_life,
	output logic [LIFE_W-1:0] b_life,
	output logic beep,
	output logic game_over
);

	logic a_hits_b;
	logic b_hits_a;
	logic b_damaged;
	logic a_damaged;

	// either bullet counts, a double match still halves only once
	assign a_hits_b = (a_shot_col == b_col) &&
		((a_up_valid && a_up_row == b_row) || (a_down_valid && a_down_row == b_row));
	assign b_hits_a = (b_shot_col == a_col) &&
		((b_up_valid && b_up_row == a_row) || (b_down_valid && b_down_row == a_row));

	assign b_damaged = shot_tick && a_hits_b && !b_defense;
	assign a_damaged = shot_tick && b_hits_a && !a_defense;

	always_ff @(posedge CLK or posedge Clear)
	begin
		if (Clear)
		begin
			a_life <= LIFE_W'(LIFE_INIT);
			b_life <= LIFE_W'(LIFE_INIT);
			beep <= 1'b0;
			game_over <= 1'b0;
		end
		else
		begin
			if (a_damaged)
				a_life <= a_life >> 1;
			if (b_damaged)
				b_life <= b_life >> 1;
			beep <= a_damaged || b_damaged; // single-cycle pulse
			game_over <= (a_life == '0) || (b_life == '0);
		end
	end

	a_life_no_rise: assert property (@(posedge CLK) disable iff (Clear)
		1'b1 |=> (a_life <= $past(a_life)) && (b_life <= $past(b_life)));

endmodule

`default_nettype wire

// ==== src/display_scan.sv ====
`timescale 1ns/1ps
`default_nettype none

module display_scan
	import game_pkg::*;
(
	input logic CLK,
	input logic Clear,
	input logic scan_tick,
	input logic a_defense,
	input logic b_defense,
	input pos_t a_row,
	input pos_t a_col,
	input pos_t b_row,
	input pos_t b_col,
	input logic a_up_valid,
	input logic a_down_valid,
	input pos_t a_up_row,
	input pos_t a_down_row,
	input pos_t a_shot_col,
	input logic b_up_valid,
	input logic b_down_valid,
	input pos_t b_up_row,
	input pos_t b_down_row,
	input pos_t b_shot_col,
	input logic [AMMO_W-1:0] a_ammo,
	input logic [AMMO_W-1:0] b_ammo,
	output logic [FIELD_W-1:0] R_color,
	output logic [FIELD_W-1:0] G_color,
	output logic [FIELD_W-1:0] B_color,
	output logic [3:0] column,
	output logic [6:0] seg,
	output logic dot,
	output logic [1:0] COM
);

	logic [2:0] slot;
	logic [FIELD_W-1:0] r_nx, g_nx, b_nx;
	pos_t col_nx;

	// single lit row, active low
	function automatic logic [FIELD_W-1:0] row_mask(input logic valid, input pos_t r);
		return valid ? ~(FIELD_W'(1) << r) : OFF_ROW;
	endfunction

	always_comb
	begin
		r_nx = OFF_ROW;
		g_nx = OFF_ROW;
		b_nx = OFF_ROW;
		col_nx = a_col;
		case (slot)
			3'd0:
			begin
				r_nx = row_mask(1'b1, a_row);
				g_nx = row_mask(a_defense, a_row); // white while defending
				b_nx = row_mask(a_defense, a_row);
			end
			3'd1:
			begin
				col_nx = b_col;
				r_nx = row_mask(b_defense, b_row);
				g_nx = row_mask(1'b1, b_row);
				b_nx = row_mask(b_defense, b_row);
			end
			3'd2:
			begin
				col_nx = a_shot_col;
				b_nx = row_mask(a_up_valid, a_up_row);
			end
			3'd3:
			begin
				col_nx = a_shot_col;
				b_nx = row_mask(a_down_valid, a_down_row);
			end
			3'd4:
			begin
				col_nx = b_shot_col;
				g_nx = row_mask(b_up_valid, b_up_row); // cyan
				b_nx = row_mask(b_up_valid, b_up_row);
			end
			default:
			begin
				col_nx = b_shot_col;
				g_nx = row_mask(b_down_valid, b_down_row);
				b_nx = row_mask(b_down_valid, b_down_row);
			end
		endcase
	end

	always_ff @(posedge CLK or posedge Clear)
	begin
		if (Clear)
		begin
			slot <= '0;
			COM <= 2'b01;
			seg <= seg_digit(AMMO_W'(AMMO_INIT));
			R_color <= OFF_ROW;
			G_color <= OFF_ROW;
			B_color <= OFF_ROW;
			column <= 4'(COLUMN_BASE + COL_INIT);
		end
		else if (scan_tick)
		begin
			slot <= (slot == 3'(SLOT_COUNT - 1)) ? '0 : slot + 1'b1;
			COM <= ~COM;
			// digit follows the digit select being switched in
			seg <= (COM == 2'b01) ? seg_digit(b_ammo) : seg_digit(a_ammo);
			R_color <= r_nx;
			G_color <= g_nx;
			B_color <= b_nx;
			column <= 4'(COLUMN_BASE) + {1'b0, col_nx};
		end
	end

	assign dot = 1'b0;

	a_slot_range: assert property (@(posedge CLK) disable iff (Clear)
		slot < 3'(SLOT_COUNT));

endmodule

`default_nettype wire

// ==== src/shooting_game.sv ====
`timescale 1ns/1ps
`default_nettype none

module shooting_game
	import game_pkg::*;
#(
	parameter int MOVE_DIV = MOVE_DIV_DEF,
	parameter int SHOT_DIV = SHOT_DIV_DEF,
	parameter int SCAN_DIV = SCAN_DIV_DEF
)
(
	input logic CLK,
	input logic Clear,
	input logic a_up,
	input logic a_down,
	input logic a_left,
	input logic a_right,
	input logic a_attack,
	input logic a_defense,
	input logic b_up,
	input logic b_down,
	input logic b_left,
	input logic b_right,
	input logic b_attack,
	input logic b_defense,
	output logic [7:0] R_color,
	output logic [7:0] G_color,
	output logic [7:0] B_color,
	output logic [3:0] column,
	output logic [3:0] a_life,
	output logic [3:0] b_life,
	output logic [6:0] seg,
	output logic dot,
	output logic [1:0] COM,
	output logic beep
);

	logic move_tick, shot_tick, scan_tick;
	logic game_over;
	pos_t a_row, a_col, b_row, b_col;
	logic a_up_valid, a_down_valid, b_up_valid, b_down_valid;
	pos_t a_up_row, a_down_row, a_shot_col;
	pos_t b_up_row, b_down_row, b_shot_col;
	logic [AMMO_W-1:0] a_ammo, b_ammo;

	tick_gen #(.MOVE_DIV(MOVE_DIV), .SHOT_DIV(SHOT_DIV), .SCAN_DIV(SCAN_DIV)) tick_gen_i (
		.CLK, .Clear, .move_tick, .shot_tick, .scan_tick
	);

	player_pos #(.ROW_INIT(A_ROW_INIT)) player_a_i (
		.CLK, .Clear, .move_tick, .up(a_up), .down(a_down), .left(a_left),
		.right(a_right), .row(a_row), .col(a_col)
	);

	player_pos #(.ROW_INIT(B_ROW_INIT)) player_b_i (
		.CLK, .Clear, .move_tick, .up(b_up), .down(b_down), .left(b_left),
		.right(b_right), .row(b_row), .col(b_col)
	);

	shot_unit shot_a_i (
		.CLK, .Clear, .shot_tick, .attack(a_attack), .game_over, .row(a_row), .col(a_col),
		.up_valid(a_up_valid), .down_valid(a_down_valid), .up_row(a_up_row),
		.down_row(a_down_row), .shot_col(a_shot_col), .ammo(a_ammo)
	);

	shot_unit shot_b_i (
		.CLK, .Clear, .shot_tick, .attack(b_attack), .game_over, .row(b_row), .col(b_col),
		.up_valid(b_up_valid), .down_valid(b_down_valid), .up_row(b_up_row),
		.down_row(b_down_row), .shot_col(b_shot_col), .ammo(b_ammo)
	);

	hit_judge hit_judge_i (
		.CLK, .Clear, .shot_tick, .a_defense, .b_defense,
		.a_row, .a_col, .b_row, .b_col,
		.a_up_valid, .a_down_valid, .a_up_row, .a_down_row, .a_shot_col,
		.b_up_valid, .b_down_valid, .b_up_row, .b_down_row, .b_shot_col,
		.a_life, .b_life, .beep, .game_over
	);

	display_scan display_scan_i (
		.CLK, .Clear, .scan_tick, .a_defense, .b_defense,
		.a_row, .a_col, .b_row, .b_col,
		.a_up_valid, .a_down_valid, .a_up_row, .a_down_row, .a_shot_col,
		.b_up_valid, .b_down_valid, .b_up_row, .b_down_row, .b_shot_col,
		.a_ammo, .b_ammo,
		.R_color, .G_color, .B_color, .column, .seg, .dot, .COM
	);

endmodule

`default_nettype wire

// ==== sim/shooting_game_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module shooting_game_tb;

	localparam int MOVE_DIV = 8;
	localparam int SHOT_DIV = 4;
	localparam int SCAN_DIV = 2;
	localparam int HOLD = 9; // move ticks, more than the field is wide
	localparam int FLIGHT = 8; // shot periods until a pair has left the field
	// 16 shots of FLIGHT+1 periods plus display checks, and 41 move periods
	localparam int LIMIT = 16 + 300 * SHOT_DIV + 60 * MOVE_DIV;

	localparam int K_AROW = 0;
	localparam int K_ACOL = 1;
	localparam int K_ADIG = 2;
	localparam int K_BDIG = 3;
	localparam int K_BROW = 4;
	localparam int K_AWHITE = 5;

	logic CLK = 1'b0;
	logic Clear;
	logic a_up, a_down, a_left, a_right, a_attack, a_defense;
	logic b_up, b_down, b_left, b_right, b_attack, b_defense;
	logic [7:0] R_color, G_color, B_color;
	logic [3:0] column, a_life, b_life;
	logic [6:0] seg;
	logic [1:0] COM;
	logic dot, beep;

	int cycles = 0;
	int req_id = 0;
	int ack_id = 0;
	int req_kind;
	int req_exp;
	string req_name;
	logic armed = 1'b0;
	logic [1:0] com_seen;
	int blue_count = 0;
	int beep_count = 0;

	shooting_game #(.MOVE_DIV(MOVE_DIV), .SHOT_DIV(SHOT_DIV), .SCAN_DIV(SCAN_DIV))
	shooting_game_i (
		.CLK, .Clear,
		.a_up, .a_down, .a_left, .a_right, .a_attack, .a_defense,
		.b_up, .b_down, .b_left, .b_right, .b_attack, .b_defense,
		.R_color, .G_color, .B_color, .column, .a_life, .b_life,
		.seg, .dot, .COM, .beep
	);

	always #2 CLK = ~CLK;

	function automatic int life_after_hits(input int hits);
		return 15 >> hits;
	endfunction

	// active low, a..g
	function automatic logic [6:0] seg_pattern(input int ammo);
		logic [6:0] p;
		case (ammo)
			0: p = 7'b0000001;
			1: p = 7'b1001111;
			2: p = 7'b0010010;
			3: p = 7'b0000110;
			4: p = 7'b1001100;
			5: p = 7'b0100100;
			6: p = 7'b0100000;
			7: p = 7'b0001111;
			8: p = 7'b0000000;
			9: p = 7'b0000100;
			default: p = 7'b1111110;
		endcase
		return p;
	endfunction

	function automatic int lit_row(input logic [7:0] colour);
		int row;
		row = -1;
		for (int i = 0; i < 8; i++)
			if (!colour[i])
				row = (row == -1) ? i : -2; // -2 when more than one row is lit
		return row;
	endfunction

	task automatic check(input string name, input int expected, input int actual);
		if (expected != actual)
		begin
			$display("Error %s: expected %0d, actual %0d", name, expected, actual);
			$display("TEST FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	always @(posedge CLK)
	begin
		cycles <= cycles + 1;
		if (cycles == LIMIT)
		begin
			$display("Timeout: the run did not finish within %0d cycles", LIMIT);
			$display("TEST FAIL");
			$fatal(1, "timeout");
		end
	end

	// only a slot registered after the request counts
	always @(negedge CLK)
	begin
		logic red_only;
		logic green_only;
		logic white;
		logic hit;
		red_only = (R_color != 8'hff) && (G_color == 8'hff) && (B_color == 8'hff);
		green_only = (R_color == 8'hff) && (G_color != 8'hff) && (B_color == 8'hff);
		white = (R_color != 8'hff) && (G_color == R_color) && (B_color == R_color);
		if (!Clear)
		begin
			if (beep)
				beep_count++;
			if (R_color == 8'hff && G_color == 8'hff && B_color != 8'hff)
				blue_count++; // A bullet on screen
			if (req_id != ack_id)
			begin
				if (!armed)
				begin
					armed = 1'b1;
					com_seen = COM;
				end
				else if (COM != com_seen)
				begin
					com_seen = COM;
					case (req_kind)
						K_AROW, K_ACOL: hit = red_only;
						K_BROW: hit = green_only;
						K_AWHITE: hit = white;
						K_ADIG: hit = (COM == 2'b01);
						default: hit = (COM == 2'b10);
					endcase
					if (hit)
					begin
						case (req_kind)
							K_AROW: check(req_name, req_exp, lit_row(R_color));
							K_ACOL: check(req_name, req_exp, int'(column));
							K_BROW: check(req_name, req_exp, lit_row(G_color));
							K_AWHITE: check(req_name, req_exp, lit_row(B_color));
							default: check(req_name, req_exp, int'(seg));
						endcase
						armed = 1'b0;
						ack_id = req_id;
					end
				end
			end
		end
	end

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge CLK);
	endtask

	task automatic expect_display(input string name, input int kind, input int expected);
		req_name = name;
		req_kind = kind;
		req_exp = expected;
		req_id++;
		while (ack_id != req_id)
			@(posedge CLK);
	endtask

	task automatic fire_and_wait(input logic side_b);
		if (side_b)
			b_attack <= 1'b1;
		else
			a_attack <= 1'b1;
		wait_cycles(SHOT_DIV); // one shot tick in this window
		a_attack <= 1'b0;
		b_attack <= 1'b0;
		wait_cycles(FLIGHT * SHOT_DIV);
	endtask

	initial
	begin
		int beeps;
		int blues;
		Clear <= 1'b1;
		{a_up, a_down, a_left, a_right, a_attack, a_defense} <= '0;
		{b_up, b_down, b_left, b_right, b_attack, b_defense} <= '0;
		wait_cycles(16);
		Clear <= 1'b0;
		wait_cycles(1);

		check("reset a_life", 15, int'(a_life));
		check("reset b_life", 15, int'(b_life));
		check("reset beep", 0, int'(beep));
		check("reset dot", 0, int'(dot));
		expect_display("reset digit A", K_ADIG, int'(seg_pattern(9)));
		expect_display("reset digit B", K_BDIG, int'(seg_pattern(9)));
		expect_display("B start row", K_BROW, 0);

		a_up <= 1'b1;
		wait_cycles(HOLD * MOVE_DIV);
		a_up <= 1'b0;
		expect_display("top edge row", K_AROW, 0);
		a_left <= 1'b1;
		wait_cycles(HOLD * MOVE_DIV);
		a_left <= 1'b0;
		expect_display("left edge column", K_ACOL, 8);
		a_right <= 1'b1;
		wait_cycles(HOLD * MOVE_DIV);
		a_right <= 1'b0;
		expect_display("right edge column", K_ACOL, 15);
		a_up <= 1'b1;
		wait_cycles(2 * MOVE_DIV);
		a_up <= 1'b0;
		expect_display("row held at top", K_AROW, 0);
		a_down <= 1'b1;
		wait_cycles(HOLD * MOVE_DIV);
		a_down <= 1'b0;
		expect_display("bottom edge row", K_AROW, 7);
		a_left <= 1'b1;
		wait_cycles(3 * MOVE_DIV);
		a_left <= 1'b0;
		expect_display("back to column 4", K_ACOL, 12);

		// B shoots down into a defended A
		a_defense <= 1'b1;
		expect_display("A white while defending", K_AWHITE, 7);
		beeps = beep_count;
		for (int k = 1; k <= 10; k++)
		begin
			fire_and_wait(1'b1);
			expect_display("B ammo digit", K_BDIG, int'(seg_pattern((k > 9) ? 0 : 9 - k)));
			check("a_life while defended", 15, int'(a_life));
		end
		check("no beep on defended hits", beeps, beep_count);
		a_defense <= 1'b0;

		beeps = beep_count;
		fire_and_wait(1'b0);
		check("b_life after one hit", life_after_hits(1), int'(b_life));
		check("beep pulse seen", 1, int'(beep_count > beeps));
		b_defense <= 1'b1;
		fire_and_wait(1'b0);
		check("b_life with defense", life_after_hits(1), int'(b_life));
		b_defense <= 1'b0;

		for (int hits = 2; hits <= 4; hits++)
		begin
			fire_and_wait(1'b0);
			check("b_life after hits", life_after_hits(hits), int'(b_life));
		end
		blues = blue_count;
		fire_and_wait(1'b0);
		expect_display("A digit after game over", K_ADIG, int'(seg_pattern(4)));
		check("no A bullet after game over", blues, blue_count);

		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
src/game_pkg.sv
src/tick_gen.sv
src/player_pos.sv
src/shot_unit.sv
src/hit_judge.sv
src/display_scan.sv
src/shooting_game.sv
sim/shooting_game_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f filelist.f \
	--top-module shooting_game_tb \
	-o shooting_game_sim

./obj_dir/shooting_game_sim
